/* Makefile */
# Verilator build and run for the all_channels testbench

VERILATOR ?= verilator
TOP       ?= tb_all_channels
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# exit status of the simulation is the pass or fail result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* sources.f */
verilog/link_pkg.sv
verilog/status_pkg.sv
verilog/chan_status_if.sv
verilog/lane_serializer.sv
verilog/lane_deserializer.sv
verilog/one_channel.sv
verilog/gt_common_lock.sv
verilog/status_regs.sv
verilog/all_channels.sv
tb/tb_all_channels.sv

/* tb/all_channels_tests.txt */
# columns: name op a b c d e, numbers in hex, - marks an unused field
# rd adr exp | wr adr data | send ch data|rand keep last arrives | expect ch | empty ch
# hold ch ready | flip ch frame_bit | nosend ch cycles | wait cycles | lock
lock_up       lock   -  -        -  -  -
status_idle   rd     0  00000303 -  -  -
errcnt_idle   rd     8  00000000 -  -  -
ctrl_reset    rd     4  00000003 -  -  -
c0_word_a     send   0  0badcafe f  0  1
c0_word_b     send   0  rand     3  1  1
c1_word_a     send   1  rand     f  1  1
c1_word_b     send   1  12345678 1  0  1
c1_rx_a       expect 1  -        -  -  -
c1_rx_b       expect 1  -        -  -  -
c0_rx_a       expect 0  -        -  -  -
c0_rx_b       expect 0  -        -  -  -
ctrl_c0_only  wr     4  00000001 -  -  -
ctrl_rdback   rd     4  00000001 -  -  -
c1_blocked    nosend 1  60       -  -  -
c0_rx_none    empty  0  -        -  -  -
ctrl_both     wr     4  00000003 -  -  -
flip_arm      flip   0  0a       -  -  -
c0_flipped    send   0  rand     f  1  0
flip_settle   wait   40 -        -  -  -
c1_rx_none    empty  1  -        -  -  -
errcnt_par    rd     8  00000100 -  -  -
status_par    rd     0  00000b03 -  -  -
errcnt_clr    wr     8  0000abcd -  -  -
errcnt_zero   rd     8  00000000 -  -  -
status_clr    rd     0  00000303 -  -  -
c1_stall      hold   1  0        -  -  -
ovf_w0        send   0  rand     f  0  1
ovf_w1        send   0  rand     7  0  1
ovf_w2        send   0  rand     3  0  1
ovf_w3        send   0  rand     1  1  1
ovf_w4        send   0  rand     f  1  0
ovf_settle    wait   40 -        -  -  -
c1_release    hold   1  1        -  -  -
ovf_rx_0      expect 1  -        -  -  -
ovf_rx_1      expect 1  -        -  -  -
ovf_rx_2      expect 1  -        -  -  -
ovf_rx_3      expect 1  -        -  -  -
ovf_drained   empty  1  -        -  -  -
status_ovf    rd     0  00000703 -  -  -

/* tb/tb_all_channels.sv */
/*
  Testbench for all_channels. Loops the two links back to each other,
  replays the step file and checks bus reads and received words.
*/
module tb_all_channels;

  localparam string TEST_FILE  = "tb/all_channels_tests.txt";
  localparam int    ACK_WAIT   = 16;    // cycles for a bus ack
  localparam int    RX_WAIT    = 400;   // cycles for a word or tx ready
  localparam int    LOCK_POLLS = 100;   // status reads before giving up

  logic              clk50;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [3:0]        wb_adr;
  logic [31:0]       wb_dat_i;
  logic [31:0]       wb_dat_o;
  logic              wb_ack;
  logic [1:0][31:0]  tx_data;    // index is the channel
  logic [1:0][3:0]   tx_keep;
  logic [1:0]        tx_valid;
  logic [1:0]        tx_last;
  logic [1:0]        tx_ready;
  logic [1:0][31:0]  rx_data;
  logic [1:0][3:0]   rx_keep;
  logic [1:0]        rx_valid;
  logic [1:0]        rx_last;
  logic [1:0]        rx_ready;
  logic [1:0]        txp;
  logic [1:0]        txn;
  logic [1:0]        rxp;
  logic [1:0]        rxn;
  logic [1:0]        inj;        // flip mask per sending channel
  logic [31:0]       rng;
  int                limit_cycles;
  logic              flip_armed;
  int                flip_ch;
  int                flip_bit;   // frame bit to flip where 0 is the start bit
  string             lines_q[$];
  logic [36:0]       exp0[$];    // words due on c0_rx as {data, keep, last}
  logic [36:0]       exp1[$];
  logic [36:0]       got0[$];    // words taken from c0_rx
  logic [36:0]       got1[$];

  // crossed links where the xor on both wires keeps the pair differential
  assign rxp[1] = txp[0] ^ inj[0];
  assign rxn[1] = txn[0] ^ inj[0];
  assign rxp[0] = txp[1] ^ inj[1];
  assign rxn[0] = txn[1] ^ inj[1];

  all_channels i_dut (
    .clk50 (clk50), .rst_n (rst_n),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_i (wb_dat_i), .wb_dat_o (wb_dat_o), .wb_ack (wb_ack),
    .c0_tx_data (tx_data[0]), .c0_tx_keep (tx_keep[0]), .c0_tx_valid (tx_valid[0]),
    .c0_tx_last (tx_last[0]), .c0_tx_ready (tx_ready[0]),
    .c0_rx_data (rx_data[0]), .c0_rx_keep (rx_keep[0]), .c0_rx_valid (rx_valid[0]),
    .c0_rx_last (rx_last[0]), .c0_rx_ready (rx_ready[0]),
    .c0_rxp (rxp[0]), .c0_rxn (rxn[0]), .c0_txp (txp[0]), .c0_txn (txn[0]),
    .c1_tx_data (tx_data[1]), .c1_tx_keep (tx_keep[1]), .c1_tx_valid (tx_valid[1]),
    .c1_tx_last (tx_last[1]), .c1_tx_ready (tx_ready[1]),
    .c1_rx_data (rx_data[1]), .c1_rx_keep (rx_keep[1]), .c1_rx_valid (rx_valid[1]),
    .c1_rx_last (rx_last[1]), .c1_rx_ready (rx_ready[1]),
    .c1_rxp (rxp[1]), .c1_rxn (rxn[1]), .c1_txp (txp[1]), .c1_txn (txn[1])
  );

  initial clk50 = 1'b0;
  always #20 clk50 = ~clk50;   // 40 unit period

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  // 32 bit xorshift with shifts 13 17 5
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // handshakes low, pins idle and no ack while reset is held
  task automatic check_reset_state();
    logic [8:0] seen;
    seen = {tx_ready, rx_valid, txp, txn, wb_ack};
    assert (seen == 9'b00_00_11_00_0) else
      stop_with_failure($sformatf("Mismatch reset_state expected %h actual %h",
                                  9'b00_00_11_00_0, seen));
  endtask

  // one classic cycle with ack one cycle after stb
  task automatic bus_access(input logic we, input logic [3:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk50);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdata;
    @(negedge clk50);
    while (!wb_ack) begin
      waited++;
      if (waited > ACK_WAIT) stop_with_failure("Wishbone access got no ack");
      @(negedge clk50);
    end
    rdata = wb_dat_o;   // valid with ack
    @(posedge clk50);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read_check(input string name, input logic [3:0] adr,
                                input logic [31:0] want);
    logic [31:0] seen;
    bus_access(1'b0, adr, 32'h0, seen);
    assert (seen == want) else
      stop_with_failure($sformatf("Mismatch %s expected %h actual %h", name, want, seen));
  endtask

  // poll status until both lanes show lane_up and lock
  task automatic wait_for_lock(input string name);
    logic [31:0] st;
    int          polls;
    st    = 32'h0;
    polls = 0;
    while ((st & 32'h0303) != 32'h0303) begin
      if (polls == LOCK_POLLS)
        stop_with_failure($sformatf("%s: lanes never came up with pll lock", name));
      bus_access(1'b0, 4'h0, 32'h0, st);
      polls++;
    end
  endtask

  task automatic send_word(input string name, input int ch, input logic [31:0] data,
                           input logic [3:0] keep, input logic last, input logic arrives);
    int waited;
    waited = 0;
    @(posedge clk50);
    #2;
    tx_data[ch]  = data;
    tx_keep[ch]  = keep;
    tx_last[ch]  = last;
    tx_valid[ch] = 1'b1;
    @(negedge clk50);
    while (!tx_ready[ch]) begin
      waited++;
      if (waited > RX_WAIT)
        stop_with_failure($sformatf("%s: channel %0d never took the word", name, ch));
      @(negedge clk50);
    end
    @(posedge clk50);   // handshake edge
    #2;
    tx_valid[ch] = 1'b0;
    if (arrives && ch == 0) exp1.push_back({data, keep, last});
    if (arrives && ch == 1) exp0.push_back({data, keep, last});
    if (flip_armed && flip_ch == ch) begin
      repeat (flip_bit + 1) @(posedge clk50);   // gap cycle then frame bits
      #2;
      inj[ch] = 1'b1;
      @(posedge clk50);
      #2;
      inj[ch]    = 1'b0;
      flip_armed = 1'b0;
    end
  endtask

  task automatic expect_word(input string name, input int ch);
    logic [36:0] want;
    logic [36:0] seen;
    int          waited;
    waited = 0;
    if (((ch == 0) ? exp0.size() : exp1.size()) == 0)
      stop_with_failure($sformatf("%s: no word was sent toward channel %0d", name, ch));
    while (((ch == 0) ? got0.size() : got1.size()) == 0) begin
      waited++;
      if (waited > RX_WAIT)
        stop_with_failure($sformatf("%s: no word arrived on channel %0d", name, ch));
      @(negedge clk50);
    end
    if (ch == 0) begin
      want = exp0.pop_front();
      seen = got0.pop_front();
    end else begin
      want = exp1.pop_front();
      seen = got1.pop_front();
    end
    assert (seen == want) else
      stop_with_failure($sformatf("Mismatch %s expected %h actual %h", name, want, seen));
  endtask

  task automatic check_empty(input string name, input int ch);
    assert (((ch == 0) ? got0.size() : got1.size()) == 0) else
      stop_with_failure($sformatf("%s: a word arrived on channel %0d that should not", name, ch));
  endtask

  // hold a word on a disabled transmitter while ready stays low
  task automatic drive_blocked(input string name, input int ch, input int cycles);
    @(posedge clk50);
    #2;
    rng          = xorshift32(rng);
    tx_data[ch]  = rng;
    tx_keep[ch]  = 4'hf;
    tx_last[ch]  = 1'b1;
    tx_valid[ch] = 1'b1;
    repeat (cycles) begin
      @(negedge clk50);
      assert (!tx_ready[ch]) else
        stop_with_failure($sformatf("%s: tx ready rose on disabled channel %0d", name, ch));
    end
    @(posedge clk50);
    #2;
    tx_valid[ch] = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // rx monitor samples both sides at the falling edge
  always @(negedge clk50) begin
    if (rx_valid[0] && rx_ready[0]) got0.push_back({rx_data[0], rx_keep[0], rx_last[0]});
    if (rx_valid[1] && rx_ready[1]) got1.push_back({rx_data[1], rx_keep[1], rx_last[1]});
  end

  // watchdog armed once the step count is known
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk50);
    stop_with_failure($sformatf("run timed out after %0d cycles", limit_cycles));
  end

  ////////////////////////////////////////////////////////////////////////////
  // step replay
  initial begin
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    string       a;
    string       b;
    string       c;
    string       d;
    string       e;
    logic [31:0] word;
    logic [31:0] dummy;
    rst_n        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = 4'h0;
    wb_dat_i     = 32'h0;
    tx_data      = '0;
    tx_keep      = '0;
    tx_valid     = 2'b00;
    tx_last      = 2'b00;
    rx_ready     = 2'b11;   // sinks take words unless held
    inj          = 2'b00;
    rng          = 32'd45;
    flip_armed   = 1'b0;
    flip_ch      = 0;
    flip_bit     = 0;
    limit_cycles = 0;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) stop_with_failure("cannot open the test step file");
    while ($fgets(line, fd) != 0) lines_q.push_back(line);
    $fclose(fd);
    limit_cycles = lines_q.size() * 200 + 2000;
    repeat (7) @(posedge clk50);
    @(negedge clk50);
    check_reset_state();
    @(posedge clk50);
    #2;
    rst_n = 1'b1;
    foreach (lines_q[i]) begin
      n = $sscanf(lines_q[i], "%s %s %s %s %s %s %s", name, op, a, b, c, d, e);
      if (n < 2 || name.getc(0) == "#") continue;   // blank or comment
      if (op == "lock") begin
        wait_for_lock(name);
      end else if (op == "rd") begin
        bus_read_check(name, 4'(a.atohex()), b.atohex());
      end else if (op == "wr") begin
        bus_access(1'b1, 4'(a.atohex()), b.atohex(), dummy);
      end else if (op == "send") begin
        if (b == "rand") begin
          rng  = xorshift32(rng);
          word = rng;
        end else begin
          word = b.atohex();
        end
        send_word(name, a.atohex(), word, 4'(c.atohex()), d.atohex() != 0,
                  e.atohex() != 0);
      end else if (op == "expect") begin
        expect_word(name, a.atohex());
      end else if (op == "empty") begin
        check_empty(name, a.atohex());
      end else if (op == "hold") begin
        @(posedge clk50);
        #2;
        rx_ready[a.atohex()] = (b.atohex() != 0);
      end else if (op == "flip") begin
        flip_ch    = a.atohex();
        flip_bit   = b.atohex();
        flip_armed = 1'b1;
      end else if (op == "nosend") begin
        drive_blocked(name, a.atohex(), b.atohex());
      end else if (op == "wait") begin
        repeat (a.atohex()) @(posedge clk50);
      end else begin
        stop_with_failure($sformatf("%s: unknown step %s", name, op));
      end
    end
    $display("All checks passed");
    $finish;
  end

endmodule

/* verilog/all_channels.sv */
/*
  All channels. Two serial links to the neighbouring channel FPGAs,
  the shared PLL model and the Wishbone status block.
*/
module all_channels (
  input  logic        clk50,
  input  logic        rst_n,
  // wishbone
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack,
  // channel 0 streams and pins
  input  logic [31:0] c0_tx_data,
  input  logic [3:0]  c0_tx_keep,
  input  logic        c0_tx_valid,
  input  logic        c0_tx_last,
  output logic        c0_tx_ready,
  output logic [31:0] c0_rx_data,
  output logic [3:0]  c0_rx_keep,
  output logic        c0_rx_valid,
  output logic        c0_rx_last,
  input  logic        c0_rx_ready,
  input  logic        c0_rxp,
  input  logic        c0_rxn,
  output logic        c0_txp,
  output logic        c0_txn,
  // channel 1 streams and pins
  input  logic [31:0] c1_tx_data,
  input  logic [3:0]  c1_tx_keep,
  input  logic        c1_tx_valid,
  input  logic        c1_tx_last,
  output logic        c1_tx_ready,
  output logic [31:0] c1_rx_data,
  output logic [3:0]  c1_rx_keep,
  output logic        c1_rx_valid,
  output logic        c1_rx_last,
  input  logic        c1_rx_ready,
  input  logic        c1_rxp,
  input  logic        c1_rxn,
  output logic        c1_txp,
  output logic        c1_txn
);

  logic pll_lock;           // shared by both lanes
  logic c1_pll_reset_req;   // only chan1 may restart the pll

  chan_status_if stat0_if ();
  chan_status_if stat1_if ();

  ////////////////////////////////////////////////////////////////////////////
  // channels
  one_channel chan0 (
    .clk50 (clk50), .rst_n (rst_n),
    .tx_data (c0_tx_data), .tx_keep (c0_tx_keep), .tx_valid (c0_tx_valid),
    .tx_last (c0_tx_last), .tx_ready (c0_tx_ready),
    .rx_data (c0_rx_data), .rx_keep (c0_rx_keep), .rx_valid (c0_rx_valid),
    .rx_last (c0_rx_last), .rx_ready (c0_rx_ready),
    .rxp (c0_rxp), .rxn (c0_rxn), .txp (c0_txp), .txn (c0_txn),
    .pll_lock (pll_lock),
    .pll_reset_req (),            // not routed to the shared pll
    .stat (stat0_if)
  );

  one_channel chan1 (
    .clk50 (clk50), .rst_n (rst_n),
    .tx_data (c1_tx_data), .tx_keep (c1_tx_keep), .tx_valid (c1_tx_valid),
    .tx_last (c1_tx_last), .tx_ready (c1_tx_ready),
    .rx_data (c1_rx_data), .rx_keep (c1_rx_keep), .rx_valid (c1_rx_valid),
    .rx_last (c1_rx_last), .rx_ready (c1_rx_ready),
    .rxp (c1_rxp), .rxn (c1_rxn), .txp (c1_txp), .txn (c1_txn),
    .pll_lock (pll_lock),
    .pll_reset_req (c1_pll_reset_req),
    .stat (stat1_if)
  );

  ////////////////////////////////////////////////////////////////////////////
  // shared pll and register block
  gt_common_lock u_gt_common (
    .clk50 (clk50), .rst_n (rst_n),
    .pll_reset_req (c1_pll_reset_req),
    .pll_lock (pll_lock)
  );

  status_regs u_status_regs (
    .clk50 (clk50), .rst_n (rst_n),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_i (wb_dat_i), .wb_dat_o (wb_dat_o), .wb_ack (wb_ack),
    .stat0 (stat0_if), .stat1 (stat1_if)
  );

endmodule

/* verilog/chan_status_if.sv */
/*
  Channel status interface. Carries one channel's link status and
  error count to the register block, and its controls back.
*/
interface chan_status_if import status_pkg::*; ();

  logic                lane_up;       // link trained and clean
  logic                pll_lock;      // shared pll locked
  logic                rx_overflow;   // sticky, frame lost on full buffer
  logic                parity_seen;   // sticky, bad frame dropped
  logic [ERRCNT_W-1:0] err_count;     // saturating parity error count
  logic                tx_enable;     // from REG_CTRL
  logic                clear_errs;    // one-cycle pulse

  modport chan (
    output lane_up, pll_lock, rx_overflow, parity_seen, err_count,
    input  tx_enable, clear_errs
  );

  modport regs (
    input  lane_up, pll_lock, rx_overflow, parity_seen, err_count,
    output tx_enable, clear_errs
  );

endinterface

/* verilog/gt_common_lock.sv */
/*
  Shared PLL model. Counts a fixed time after reset or after a
  reset request from a channel, then holds lock.
*/
module gt_common_lock import link_pkg::*; (
  input  logic clk50,
  input  logic rst_n,
  input  logic pll_reset_req,   // restarts the lock sequence
  output logic pll_lock
);

  logic [LOCK_W-1:0] lock_cnt;   // stops at LOCK_CYCLES

  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      lock_cnt <= '0;
    end else if (pll_reset_req) begin
      lock_cnt <= '0;              // drop lock, count again
    end else if (!pll_lock) begin
      lock_cnt <= lock_cnt + 1'b1;
    end
  end

  assign pll_lock = (lock_cnt == LOCK_W'(LOCK_CYCLES));

endmodule

/* verilog/lane_deserializer.sv */
/*
  Lane deserializer. Samples rxp/rxn, finds the start bit, rebuilds
  and parity checks each frame, and buffers good words in a small FIFO.
*/
module lane_deserializer import link_pkg::*; (
  input  logic         clk50,
  input  logic         rst_n,
  input  logic         rxp,
  input  logic         rxn,
  output stream_word_t m_rx,
  output logic         m_valid,
  input  logic         m_ready,
  output logic         frame_ok,     // word written to buffer
  output logic         parity_err,   // frame dropped
  output logic         overflow,     // good frame, buffer full
  output logic         line_fault    // rxp == rxn
);

  logic                 rxp_q;
  logic                 rxn_q;
  logic [CNT_W-1:0]     bit_cnt;   // bits still to collect
  logic [WORD_BITS:0]   rx_sh;     // parity at top, payload below
  logic                 done;      // full frame in rx_sh
  logic                 par_ok;
  stream_word_t         mem [RX_DEPTH];
  logic [RX_AW-1:0]     wr_ptr;
  logic [RX_AW-1:0]     rd_ptr;
  logic [RX_AW:0]       count;
  logic                 full;
  logic                 push;
  logic                 pop;

  // pin sampling, reset to the idle pattern
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      rxp_q <= 1'b1;
      rxn_q <= 1'b0;
    end else begin
      rxp_q <= rxp;
      rxn_q <= rxn;
    end
  end

  assign line_fault = (rxp_q == rxn_q);

  ////////////////////////////////////////////////////////////////////////////
  // frame assembly
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (line_fault) begin
        bit_cnt <= '0;                         // abort, wait for next start
      end else if (bit_cnt != '0) begin
        bit_cnt <= bit_cnt - 1'b1;
        done    <= (bit_cnt == CNT_W'(1));     // last bit shifting in
      end else if (!rxp_q) begin
        bit_cnt <= CNT_W'(FRAME_BITS - 1);     // start bit seen
      end
    end
  end

  always_ff @(posedge clk50) begin
    if (bit_cnt != '0) begin
      rx_sh <= {rxp_q, rx_sh[WORD_BITS:1]};   // lsb arrives first
    end
  end

  // total weight of payload + parity
  assign par_ok = ((^rx_sh) == ~PARITY_EVEN);

  ////////////////////////////////////////////////////////////////////////////
  // receive buffer
  assign full       = (count == (RX_AW + 1)'(RX_DEPTH));
  assign push       = done && par_ok && !full;
  assign pop        = m_valid && m_ready;
  assign frame_ok   = push;
  assign overflow   = done && par_ok && full;    // frame lost
  assign parity_err = done && !par_ok;

  always_ff @(posedge clk50) begin
    if (push) begin
      mem[wr_ptr] <= stream_word_t'(rx_sh[WORD_BITS-1:0]);
    end
  end

  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + (RX_AW + 1)'(push) - (RX_AW + 1)'(pop);
    end
  end

  assign m_valid = (count != '0);
  assign m_rx    = mem[rd_ptr];

endmodule

/* verilog/lane_serializer.sv */
/*
  Lane serializer. Takes one stream word per handshake, adds start
  and parity bits, and shifts the frame out on txp/txn.
*/
module lane_serializer import link_pkg::*; (
  input  logic         clk50,
  input  logic         rst_n,
  input  logic         enable,    // lane up, locked and tx enabled
  input  stream_word_t s_tx,
  input  logic         s_valid,
  output logic         s_ready,
  output logic         txp,
  output logic         txn
);

  logic [CNT_W-1:0]      bit_cnt;   // bits left in frame, 0 = idle
  logic [FRAME_BITS-1:0] tx_sh;     // frame, lsb goes out next
  logic                  load;

  // take a word only between frames
  assign s_ready = enable && (bit_cnt == '0);
  assign load    = s_valid && s_ready;

  assign txn = ~txp;   // differential pair

  ////////////////////////////////////////////////////////////////////////////
  // bit counter and line driver
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
      txp     <= 1'b1;   // idle high
    end else if (load) begin
      bit_cnt <= CNT_W'(FRAME_BITS);
      txp     <= 1'b1;   // gap cycle before the start bit
    end else if (bit_cnt != '0) begin
      bit_cnt <= bit_cnt - 1'b1;
      txp     <= tx_sh[0];
    end else begin
      txp <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame shifter
  // layout lsb first: start 0, payload, parity
  always_ff @(posedge clk50) begin
    if (load) begin
      tx_sh <= {^{s_tx, ~PARITY_EVEN}, s_tx, 1'b0};
    end else if (bit_cnt != '0) begin
      tx_sh <= tx_sh >> 1;
    end
  end

endmodule

/* verilog/link_pkg.sv */
/*
  Link package. Serial frame format, stream word layout and the
  lane, lock and receive buffer constants shared by both lanes.
*/
package link_pkg;

  // one stream word; keep sits in the low bits so it leaves the pin first
  typedef struct packed {
    logic [31:0] data;   // payload
    logic        last;   // end of packet
    logic [3:0]  keep;   // byte enables
  } stream_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // frame layout on the wire
  // start(0), keep, last, data lsb first, then parity; idle is txp high
  localparam int   WORD_BITS   = $bits(stream_word_t);     // 37
  localparam int   FRAME_BITS  = WORD_BITS + 2;            // 39 incl start + parity
  localparam int   CNT_W       = $clog2(FRAME_BITS + 1);   // bit counter width
  localparam logic PARITY_EVEN = 1'b1;                     // payload + parity has even weight

  ////////////////////////////////////////////////////////////////////////////
  // lane and lock timing
  localparam int IDLE_RUN    = 16;                        // idle samples before lane_up
  localparam int IDLE_W      = $clog2(IDLE_RUN + 1);      // idle run counter width
  localparam int LOCK_CYCLES = 32;                        // cycles from reset release to pll lock
  localparam int LOCK_W      = $clog2(LOCK_CYCLES + 1);   // lock counter width

  // receive buffer
  localparam int RX_DEPTH = 4;                  // words
  localparam int RX_AW    = $clog2(RX_DEPTH);   // pointer width

endpackage

/* verilog/one_channel.sv */
/*
  One serial channel. Serializer and deserializer for a lane, plus
  lane-up tracking, pll reset request and error bookkeeping.
*/
module one_channel import link_pkg::*; (
  input  logic        clk50,
  input  logic        rst_n,
  // transmit stream
  input  logic [31:0] tx_data,
  input  logic [3:0]  tx_keep,
  input  logic        tx_valid,
  input  logic        tx_last,
  output logic        tx_ready,
  // receive stream
  output logic [31:0] rx_data,
  output logic [3:0]  rx_keep,
  output logic        rx_valid,
  output logic        rx_last,
  input  logic        rx_ready,
  // pins
  input  logic        rxp,
  input  logic        rxn,
  output logic        txp,
  output logic        txn,
  // shared pll
  input  logic        pll_lock,
  output logic        pll_reset_req,
  chan_status_if.chan stat
);

  stream_word_t      tx_word;
  stream_word_t      rx_word;
  logic              parity_err;
  logic              overflow;
  logic              line_fault;
  logic              fault_q;    // fault on previous sample
  logic [IDLE_W-1:0] idle_cnt;   // saturating count of idle samples

  assign tx_word  = '{data: tx_data, last: tx_last, keep: tx_keep};
  assign rx_data  = rx_word.data;
  assign rx_keep  = rx_word.keep;
  assign rx_last  = rx_word.last;

  lane_serializer u_ser (
    .clk50   (clk50),
    .rst_n   (rst_n),
    .enable  (stat.lane_up && pll_lock && stat.tx_enable),
    .s_tx    (tx_word),
    .s_valid (tx_valid),
    .s_ready (tx_ready),
    .txp     (txp),
    .txn     (txn)
  );

  lane_deserializer u_des (
    .clk50      (clk50),
    .rst_n      (rst_n),
    .rxp        (rxp),
    .rxn        (rxn),
    .m_rx       (rx_word),
    .m_valid    (rx_valid),
    .m_ready    (rx_ready),
    .frame_ok   (),
    .parity_err (parity_err),
    .overflow   (overflow),
    .line_fault (line_fault)
  );

  ////////////////////////////////////////////////////////////////////////////
  // lane up tracking
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      idle_cnt     <= '0;
      fault_q      <= 1'b0;
      stat.lane_up <= 1'b0;
    end else begin
      fault_q <= line_fault;
      if (!(rxp && !rxn)) begin
        idle_cnt <= '0;                       // frame bits or fault
      end else if (idle_cnt != IDLE_W'(IDLE_RUN)) begin
        idle_cnt <= idle_cnt + 1'b1;
      end
      if (line_fault || !pll_lock) begin
        stat.lane_up <= 1'b0;
      end else if (idle_cnt == IDLE_W'(IDLE_RUN)) begin
        stat.lane_up <= 1'b1;                 // full idle run seen
      end
    end
  end

  // fault held over two samples asks for a pll restart
  assign pll_reset_req = line_fault && fault_q;
  assign stat.pll_lock = pll_lock;

  // sticky bits and saturating error count
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      stat.rx_overflow <= 1'b0;
      stat.parity_seen <= 1'b0;
      stat.err_count   <= '0;
    end else if (stat.clear_errs) begin
      stat.rx_overflow <= 1'b0;
      stat.parity_seen <= 1'b0;
      stat.err_count   <= '0;
    end else begin
      if (overflow) stat.rx_overflow <= 1'b1;
      if (parity_err) begin
        stat.parity_seen <= 1'b1;
        if (stat.err_count != '1) stat.err_count <= stat.err_count + 1'b1;
      end
    end
  end

endmodule

/* verilog/status_pkg.sv */
/*
  Status package. Register map, bit positions and reset values
  of the Wishbone status block shared by both channels.
*/
package status_pkg;

  // register addresses on wb_adr
  localparam logic [3:0] REG_STATUS = 4'h0;   // read only
  localparam logic [3:0] REG_CTRL   = 4'h4;   // read/write
  localparam logic [3:0] REG_ERRCNT = 4'h8;   // read counts, write clears

  ////////////////////////////////////////////////////////////////////////////
  // REG_STATUS, one byte per channel
  localparam int CH_BITS     = 8;   // channel c at bits 8c+7 .. 8c
  localparam int ST_LANE_UP  = 0;
  localparam int ST_PLL_LOCK = 1;
  localparam int ST_RX_OVF   = 2;   // sticky
  localparam int ST_PARITY   = 3;   // sticky

  ////////////////////////////////////////////////////////////////////////////
  // REG_CTRL
  localparam int         CTRL_W     = 2;       // tx_enable, bit per channel
  localparam logic [1:0] CTRL_RESET = 2'b11;   // both transmitters on

  // REG_ERRCNT
  localparam int ERRCNT_W = 8;   // per channel, saturates at 255

endpackage

/* verilog/status_regs.sv */
/*
  Status registers. Wishbone classic slave that merges both channels'
  status and error counts and holds the transmit enable control.
*/
module status_regs import status_pkg::*; (
  input  logic        clk50,
  input  logic        rst_n,
  // wishbone classic
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack,
  // channel status
  chan_status_if.regs stat0,
  chan_status_if.regs stat1
);

  logic [CTRL_W-1:0] ctrl;          // tx_enable per channel
  logic              clr_q;         // errcnt write seen
  logic              req;           // new bus cycle
  logic              wr;
  logic [31:0]       status_word;
  logic [31:0]       errcnt_word;
  logic [31:0]       rd_data;

  // one status byte
  function automatic logic [CH_BITS-1:0] chan_bits(input logic up, input logic lock,
                                                   input logic ovf, input logic par);
    logic [CH_BITS-1:0] b;
    b              = '0;
    b[ST_LANE_UP]  = up;
    b[ST_PLL_LOCK] = lock;
    b[ST_RX_OVF]   = ovf;
    b[ST_PARITY]   = par;
    return b;
  endfunction

  assign req = wb_cyc && wb_stb && !wb_ack;   // ack once per access
  assign wr  = req && wb_we;

  assign status_word = {{(32 - 2*CH_BITS){1'b0}},
                        chan_bits(stat1.lane_up, stat1.pll_lock,
                                  stat1.rx_overflow, stat1.parity_seen),
                        chan_bits(stat0.lane_up, stat0.pll_lock,
                                  stat0.rx_overflow, stat0.parity_seen)};
  assign errcnt_word = {{(32 - 2*ERRCNT_W){1'b0}}, stat1.err_count, stat0.err_count};

  ////////////////////////////////////////////////////////////////////////////
  // read mux, unmapped reads as zero
  always_comb begin
    case (wb_adr)
      REG_STATUS: rd_data = status_word;
      REG_CTRL:   rd_data = {{(32 - CTRL_W){1'b0}}, ctrl};
      REG_ERRCNT: rd_data = errcnt_word;
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      ctrl   <= CTRL_RESET;
      clr_q  <= 1'b0;
    end else begin
      wb_ack <= req;
      clr_q  <= wr && (wb_adr == REG_ERRCNT);          // any value clears
      if (wr && wb_adr == REG_CTRL) ctrl <= wb_dat_i[CTRL_W-1:0];
    end
  end

  always_ff @(posedge clk50) begin
    if (req) wb_dat_o <= rd_data;   // valid with ack
  end

  assign stat0.tx_enable  = ctrl[0];
  assign stat1.tx_enable  = ctrl[1];
  assign stat0.clear_errs = clr_q;
  assign stat1.clear_errs = clr_q;

endmodule
